// File: bench/tb_lsu_wb.sv
// Self-checking bench; slave memory is 32 double words, so only address bits 7:0 are exercised
`include "lsu_config.svh"

module tb_lsu_wb;

  import lsu_pkg::*;

  localparam int N_MIX = 300;
  // Directed accesses: store sweep 64, unsigned loads 32, signed sweep 128, hold test 3
  localparam int N_ACC = 227 + N_MIX;

  logic clk_i;
  logic arst_n_i;
  logic f_req_i;
  logic f_we_i;
  adr_t f_adr_i;
  acc_size_e f_siz_i;
  logic f_signed_i;
  dword_t f_dat_i;
  logic f_busy_o;
  logic f_done_o;
  dword_t f_dat_o;
  logic wb_cyc_o;
  logic wb_stb_o;
  logic wb_we_o;
  adr_t wb_adr_o;
  sel_t wb_sel_o;
  dword_t wb_dat_o;
  dword_t wb_dat_i;
  logic wb_ack_i;

  integer seed = 32'h47263b2d;
  integer ack_seed = 32'h47263b2d;
  dword_t mem [32];
  dword_t model_mem [32];
  dec_req_t bus_q [$];
  dword_t done_q [$];
  dec_req_t cur_bus;
  logic in_cyc = 1'b0;
  logic hold_ack = 1'b0;
  int wait_cnt;
  int idx;
  int n_issued = 0;
  int done_cnt = 0;
  dword_t d;
  adr_t a;

  lsu_wb_top i_lsu_wb_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic report_failure();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_sel(input string name, input sel_t got, input sel_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_dword(input string name, input dword_t got, input dword_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_adr(input string name, input adr_t got, input adr_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_done(input int got, input int exp);
    if (got != exp) begin
      $display("ERR f_done_o count got %h expected %h", got, exp);
      report_failure();
    end
  endtask

  function automatic dword_t rand_dword();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic adr_t rand_adr(input int off);
    adr_t r;
    r = '0;
    r[7:3] = $random(seed);
    r[2:0] = off;
    return r;
  endfunction

  // Called on a falling edge; holds the request until busy is low, then updates the model
  task automatic issue(input logic we, input adr_t adr, input acc_size_e siz, input logic sgn,
                       input dword_t dat);
    dec_req_t bus;
    dword_t word;
    dword_t res;
    int nb;
    int base;
    f_req_i = 1'b1;
    f_we_i = we;
    f_adr_i = adr;
    f_siz_i = siz;
    f_signed_i = sgn;
    f_dat_i = dat;
    while (f_busy_o !== 1'b0) @(negedge clk_i);
    nb = 1 << siz;
    base = int'(adr[2:0]) / nb * nb;
    word = model_mem[adr[7:3]];
    res = '0;
    bus = '0;
    bus.adr = {adr[`LSU_ADR_W-1:3], 3'b000};
    bus.we = we;
    for (int i = 0; i < `LSU_DAT_W / 8; i++) begin
      bus.dat[8*i +: 8] = dat[8*(i % nb) +: 8];
      if (i >= base && i < base + nb) begin
        bus.sel[i] = 1'b1;
        if (we) word[8*i +: 8] = dat[8*(i - base) +: 8];
        else res[8*(i - base) +: 8] = word[8*i +: 8];
      end
    end
    if (!we && sgn && res[8*nb-1]) begin
      for (int i = nb; i < 8; i++) res[8*i +: 8] = 8'hff;
    end
    if (we) model_mem[adr[7:3]] = word;
    bus_q.push_back(bus);
    done_q.push_back(res);
    n_issued++;
    @(negedge clk_i);
    f_req_i = 1'b0;
  endtask

  // Wishbone memory slave with random wait states, checking each open cycle
  always @(negedge clk_i) begin
    if (wb_ack_i) begin
      wb_ack_i = 1'b0;
      in_cyc = 1'b0;
    end else if (wb_cyc_o) begin
      check_flag("wb_stb_o", wb_stb_o, 1'b1);
      if (!in_cyc) begin
        if (bus_q.size() == 0) begin
          $display("Bus cycle opened with no access outstanding");
          report_failure();
        end
        in_cyc = 1'b1;
        cur_bus = bus_q.pop_front();
        wait_cnt = {$random(ack_seed)} % 4;
      end
      check_adr("wb_adr_o", wb_adr_o, cur_bus.adr);
      check_flag("wb_we_o", wb_we_o, cur_bus.we);
      check_sel("wb_sel_o", wb_sel_o, cur_bus.sel);
      if (cur_bus.we) check_dword("wb_dat_o", wb_dat_o, cur_bus.dat);
      if (wait_cnt == 0 && !hold_ack) begin
        idx = wb_adr_o[7:3];
        wb_ack_i = 1'b1;
        wb_dat_i = mem[idx];
        for (int i = 0; i < 8; i++) begin
          if (wb_we_o && wb_sel_o[i]) mem[idx][8*i +: 8] = wb_dat_o[8*i +: 8];
        end
      end else if (wait_cnt > 0) begin
        wait_cnt--;
      end
    end else begin
      check_flag("wb_stb_o", wb_stb_o, 1'b0);
    end
  end

  always @(negedge clk_i) begin
    if (f_done_o === 1'b1) begin
      if (done_q.size() == 0) begin
        $display("Completion pulse with no access outstanding");
        report_failure();
      end
      check_dword("f_dat_o", f_dat_o, done_q.pop_front());
      done_cnt++;
    end
  end

  initial begin
    repeat (N_ACC * 20 + 200) @(posedge clk_i);
    $display("Timeout: accesses did not complete within the expected time");
    report_failure();
  end

  initial begin
    arst_n_i = 1'b0;
    f_req_i = 1'b0;
    f_we_i = 1'b0;
    f_adr_i = '0;
    f_siz_i = SIZE_B;
    f_signed_i = 1'b0;
    f_dat_i = '0;
    wb_dat_i = '0;
    wb_ack_i = 1'b0;
    for (int i = 0; i < 32; i++) begin
      mem[i] = rand_dword();
      model_mem[i] = mem[i];
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_flag("f_busy_o", f_busy_o, 1'b0);
    check_flag("f_done_o", f_done_o, 1'b0);
    check_flag("wb_cyc_o", wb_cyc_o, 1'b0);
    check_dword("f_dat_o", f_dat_o, '0);
    // Each store is read back as a double word to see the untouched lanes
    for (int s = 0; s < 4; s++) begin
      for (int o = 0; o < 8; o++) begin
        a = rand_adr(o);
        issue(1'b1, a, acc_size_e'(s), 1'b0, rand_dword());
        issue(1'b0, a, SIZE_D, 1'b0, rand_dword());
      end
    end
    for (int s = 0; s < 4; s++) begin
      for (int o = 0; o < 8; o++) issue(1'b0, rand_adr(o), acc_size_e'(s), 1'b0, rand_dword());
    end
    // Signed loads after a store that forces the top bit both ways
    for (int s = 0; s < 4; s++) begin
      for (int o = 0; o < 8; o++) begin
        for (int t = 0; t < 2; t++) begin
          a = rand_adr(o);
          d = rand_dword();
          d[(8 << s) - 1] = t[0];
          issue(1'b1, a, acc_size_e'(s), 1'b0, d);
          issue(1'b0, a, acc_size_e'(s), 1'b1, rand_dword());
        end
      end
    end
    for (int n = 0; n < N_MIX; n++) begin
      issue($random(seed), rand_adr({$random(seed)} % 8), acc_size_e'({$random(seed)} % 4),
            $random(seed), rand_dword());
      repeat ({$random(seed)} % 3) @(negedge clk_i);
    end
    wait (done_cnt == n_issued);
    // Withheld ack with a second request parked in decode
    hold_ack = 1'b1;
    issue(1'b0, rand_adr(3), SIZE_W, 1'b1, rand_dword());
    issue(1'b1, rand_adr(5), SIZE_H, 1'b0, rand_dword());
    repeat (6) begin
      @(negedge clk_i);
      check_flag("f_busy_o", f_busy_o, 1'b1);
    end
    hold_ack = 1'b0;
    issue(1'b0, rand_adr(6), SIZE_B, 1'b0, rand_dword());
    // Two accesses still in flight drain within a few bus cycles
    for (int c = 0; c < 40 && done_cnt != n_issued; c++) @(negedge clk_i);
    repeat (8) @(negedge clk_i);
    check_done(done_cnt, n_issued);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: hdl/lsu_config.svh
// Only the address width may change; the lane and align logic expect a 64-bit bus
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Width of the byte address on both ports
`define LSU_ADR_W 32

// Wishbone data width in bits
// Eight byte lanes are hard-wired into select and extension logic
`define LSU_DAT_W 64

`endif

// File: hdl/lsu_load_align.sv
// Never stalls; f_dat_o reads zero for stores and holds its value between completions
module lsu_load_align (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  lsu_pkg::rd_rsp_t rsp_i,
  input  logic             rsp_vld_i,
  output logic             f_done_o,
  output lsu_pkg::dword_t  f_dat_o
);

  import lsu_pkg::*;

  logic [5:0] sh;
  dword_t     shifted;
  dword_t     ext;
  logic       done_q;
  dword_t     dat_q;

  // Bring the addressed lanes down to bit 0
  always_comb begin
    sh = '0;
    case (rsp_i.siz)
      SIZE_W:  sh = {rsp_i.lane[2], 5'b0};
      SIZE_H:  sh = {rsp_i.lane[2:1], 4'b0};
      SIZE_B:  sh = {rsp_i.lane, 3'b0};
      default: sh = '0;
    endcase
    shifted = rsp_i.dat >> sh;
  end

  always_comb begin
    ext = shifted;
    case (rsp_i.siz)
      SIZE_W:  ext = {{32{rsp_i.sgn & shifted[31]}}, shifted[31:0]};
      SIZE_H:  ext = {{48{rsp_i.sgn & shifted[15]}}, shifted[15:0]};
      SIZE_B:  ext = {{56{rsp_i.sgn & shifted[7]}}, shifted[7:0]};
      default: ext = shifted;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q <= 1'b0;
      dat_q  <= '0;
    end else begin
      done_q <= rsp_vld_i;
      if (rsp_vld_i) begin
        dat_q <= rsp_i.we ? '0 : ext;
      end
    end
  end

  assign f_done_o = done_q;
  assign f_dat_o  = dat_q;

  // A completion always hands back defined data
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    f_done_o |-> !$isunknown(f_dat_o));

endmodule

// File: hdl/lsu_pkg.sv
// Shared types for the bridge stages; needs lsu_config.svh on the include path
`include "lsu_config.svh"

package lsu_pkg;

  typedef logic [`LSU_ADR_W-1:0]              adr_t;
  typedef logic [`LSU_DAT_W-1:0]              dword_t;
  typedef logic [`LSU_DAT_W/8-1:0]            sel_t;
  typedef logic [$clog2(`LSU_DAT_W/8)-1:0]    lane_t;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } acc_size_e;

  typedef enum logic {
    WB_IDLE,
    WB_BUSY
  } wb_state_e;

  // Decoded request held between decode and bus master
  typedef struct packed {
    adr_t      adr;
    logic      we;
    acc_size_e siz;
    logic      sgn;
    lane_t     lane;
    sel_t      sel;
    dword_t    dat;
  } dec_req_t;

  // Raw read word plus what the align stage needs to pick lanes
  typedef struct packed {
    acc_size_e siz;
    logic      sgn;
    lane_t     lane;
    logic      we;
    dword_t    dat;
  } rd_rsp_t;

endpackage

// File: hdl/lsu_req_decode.sv
// Requests are taken only while busy_o is low; address bits below the size are ignored
module lsu_req_decode (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               f_req_i,
  input  logic               f_we_i,
  input  lsu_pkg::adr_t      f_adr_i,
  input  lsu_pkg::acc_size_e f_siz_i,
  input  logic               f_signed_i,
  input  lsu_pkg::dword_t    f_dat_i,
  input  logic               take_i,
  output logic               busy_o,
  output lsu_pkg::dec_req_t  req_o,
  output logic               req_vld_o
);

  import lsu_pkg::*;

  dec_req_t req_d;
  dec_req_t req_q;
  logic     req_vld_q;
  logic     accept;
  lane_t    lane;

  assign lane   = lane_t'(f_adr_i);
  // Full entry blocks new requests unless the master drains it now
  assign busy_o = req_vld_q && !take_i;
  assign accept = f_req_i && !busy_o;

  always_comb begin
    req_d.adr  = f_adr_i;
    req_d.we   = f_we_i;
    req_d.siz  = f_siz_i;
    req_d.sgn  = f_signed_i;
    req_d.lane = lane;
    req_d.sel  = '0;
    req_d.dat  = '0;
    case (f_siz_i)
      SIZE_D: begin
        req_d.sel = 8'hff;
        req_d.dat = f_dat_i;
      end
      SIZE_W: begin
        req_d.sel = lane[2] ? 8'hf0 : 8'h0f;
        req_d.dat = {2{f_dat_i[31:0]}};
      end
      SIZE_H: begin
        req_d.sel = 8'h03 << {lane[2:1], 1'b0};
        req_d.dat = {4{f_dat_i[15:0]}};
      end
      SIZE_B: begin
        req_d.sel = 8'h01 << lane;
        req_d.dat = {8{f_dat_i[7:0]}};
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_vld_q <= 1'b0;
    end else if (accept) begin
      req_vld_q <= 1'b1;
    end else if (take_i) begin
      req_vld_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_d;
    end
  end

  assign req_o     = req_q;
  assign req_vld_o = req_vld_q;

  // A waiting entry survives untouched until the master takes it
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_vld_q && !take_i |=> req_vld_q && $stable(req_q));

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    accept |-> !$isunknown({f_siz_i, f_adr_i}));

endmodule

// File: hdl/lsu_wb_master.sv
// Wishbone classic single cycles only; err, retry and bursts are not supported
module lsu_wb_master (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  lsu_pkg::dec_req_t req_i,
  input  logic              req_vld_i,
  input  lsu_pkg::dword_t   wb_dat_i,
  input  logic              wb_ack_i,
  output logic              take_o,
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  output lsu_pkg::adr_t     wb_adr_o,
  output lsu_pkg::sel_t     wb_sel_o,
  output lsu_pkg::dword_t   wb_dat_o,
  output lsu_pkg::rd_rsp_t  rsp_o,
  output logic              rsp_vld_o
);

  import lsu_pkg::*;

  wb_state_e state_q;
  logic      we_q;
  adr_t      adr_q;
  sel_t      sel_q;
  dword_t    dat_q;
  rd_rsp_t   rsp_q;
  logic      rsp_vld_q;
  logic      ack;

  assign take_o = (state_q == WB_IDLE) && req_vld_i;
  // Stray acks outside a cycle are dropped here
  assign ack    = (state_q == WB_BUSY) && wb_ack_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= WB_IDLE;
      we_q      <= 1'b0;
      rsp_vld_q <= 1'b0;
    end else begin
      rsp_vld_q <= ack;
      case (state_q)
        WB_IDLE: begin
          if (req_vld_i) begin
            state_q <= WB_BUSY;
            we_q    <= req_i.we;
          end
        end
        WB_BUSY: begin
          if (wb_ack_i) begin
            state_q <= WB_IDLE;
          end
        end
        default: state_q <= WB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_o) begin
      adr_q      <= req_i.adr & ~adr_t'(7);
      sel_q      <= req_i.sel;
      dat_q      <= req_i.dat;
      rsp_q.siz  <= req_i.siz;
      rsp_q.sgn  <= req_i.sgn;
      rsp_q.lane <= req_i.lane;
      rsp_q.we   <= req_i.we;
    end
    if (ack) begin
      rsp_q.dat <= wb_dat_i;
    end
  end

  assign wb_cyc_o  = (state_q == WB_BUSY);
  assign wb_stb_o  = (state_q == WB_BUSY);
  assign wb_we_o   = we_q;
  assign wb_adr_o  = adr_q;
  assign wb_sel_o  = sel_q;
  assign wb_dat_o  = dat_q;
  assign rsp_o     = rsp_q;
  assign rsp_vld_o = rsp_vld_q;

  // Slave sees a steady request until it answers
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable({wb_we_o, wb_adr_o, wb_sel_o, wb_dat_o}));

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_cyc_o |-> wb_sel_o != '0);

endmodule

// File: hdl/lsu_wb_top.sv
// Three-stage load/store bridge to 64-bit Wishbone classic; at most two accesses in flight
module lsu_wb_top (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               f_req_i,
  input  logic               f_we_i,
  input  lsu_pkg::adr_t      f_adr_i,
  input  lsu_pkg::acc_size_e f_siz_i,
  input  logic               f_signed_i,
  input  lsu_pkg::dword_t    f_dat_i,
  output logic               f_busy_o,
  output logic               f_done_o,
  output lsu_pkg::dword_t    f_dat_o,
  output logic               wb_cyc_o,
  output logic               wb_stb_o,
  output logic               wb_we_o,
  output lsu_pkg::adr_t      wb_adr_o,
  output lsu_pkg::sel_t      wb_sel_o,
  output lsu_pkg::dword_t    wb_dat_o,
  input  lsu_pkg::dword_t    wb_dat_i,
  input  logic               wb_ack_i
);

  import lsu_pkg::*;

  dec_req_t dec_req;
  logic     dec_vld;
  logic     take;
  rd_rsp_t  rsp;
  logic     rsp_vld;

  lsu_req_decode i_lsu_req_decode (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .f_req_i    (f_req_i),
    .f_we_i     (f_we_i),
    .f_adr_i    (f_adr_i),
    .f_siz_i    (f_siz_i),
    .f_signed_i (f_signed_i),
    .f_dat_i    (f_dat_i),
    .take_i     (take),
    .busy_o     (f_busy_o),
    .req_o      (dec_req),
    .req_vld_o  (dec_vld)
  );

  lsu_wb_master i_lsu_wb_master (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (dec_req),
    .req_vld_i (dec_vld),
    .wb_dat_i  (wb_dat_i),
    .wb_ack_i  (wb_ack_i),
    .take_o    (take),
    .wb_cyc_o  (wb_cyc_o),
    .wb_stb_o  (wb_stb_o),
    .wb_we_o   (wb_we_o),
    .wb_adr_o  (wb_adr_o),
    .wb_sel_o  (wb_sel_o),
    .wb_dat_o  (wb_dat_o),
    .rsp_o     (rsp),
    .rsp_vld_o (rsp_vld)
  );

  lsu_load_align i_lsu_load_align (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .rsp_i     (rsp),
    .rsp_vld_i (rsp_vld),
    .f_done_o  (f_done_o),
    .f_dat_o   (f_dat_o)
  );

endmodule

// File: sources.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_req_decode.sv
hdl/lsu_wb_master.sv
hdl/lsu_load_align.sv
hdl/lsu_wb_top.sv
bench/tb_lsu_wb.sv
